// File: vlog.f
aud_cfg_pkg.sv
aud_types_pkg.sv
aud_ctrl.sv
aud_recorder.sv
aud_dsp.sv
aud_player.sv
aud_top.sv
aud_assertions.sv
tb_aud_top.sv

// File: Makefile
SRCS := $(wildcard *.sv)

.PHONY: run clean

obj_dir/Vtb_aud_top: $(SRCS) vlog.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_aud_top \
		-f vlog.f -o Vtb_aud_top

run: obj_dir/Vtb_aud_top
	./obj_dir/Vtb_aud_top | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// File: tb_aud_top.sv
`timescale 1ns/1ps

module tb_aud_top;

	// frames used by all tests together, rounded up per test
	localparam int RUN_FRAMES = 22 + 24 + 10 + 24 + 44 + 84 + 27 + 7;
	localparam longint TIMEOUT_NS = longint'(RUN_FRAMES + 20) * 128 * 40;

	logic i_clk;
	logic i_rst_n;
	logic i_start;
	logic i_pause;
	logic i_stop;
	logic i_play_sel;
	logic [3:0] i_speed;
	logic i_fast;
	logic i_slow;
	logic i_interp;
	logic i_aud_bclk;
	logic i_aud_lrck;
	logic i_aud_adcdat;
	logic o_aud_dacdat;
	logic [19:0] o_sram_addr;
	wire [15:0] io_sram_dq;
	logic o_sram_we_n;
	aud_types_pkg::ctrl_state_e o_state;
	logic [19:0] o_end_addr;

	integer seed = 81914;
	int cyc = 0;
	int frame_cnt = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int end_exp = 0;
	logic [15:0] adc_word = '0;
	logic [15:0] dec_sh = '0;
	// adc word sent in each frame, and the words now held in sram
	logic [15:0] sent [0:511];
	logic [15:0] rec_words [0:255];
	logic [15:0] mem [0:255];
	logic [15:0] ref_q [$];
	logic [15:0] exp_word [$];
	int exp_frame [$];

	aud_top UUT (.*);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	// async sram, write lands at the end of the we_n cycle
	always @(posedge i_clk) begin
		if (!o_sram_we_n) begin
			mem[o_sram_addr[7:0]] <= io_sram_dq;
		end
	end
	assign io_sram_dq = o_sram_we_n ? mem[o_sram_addr[7:0]] : 16'hzzzz;

	// codec, 128 clocks per frame, bclk = cyc[1], left word in the low lrck half
	always @(posedge i_clk) begin : codec_gen
		logic [15:0] nxt;
		cyc <= (cyc == 127) ? 0 : cyc + 1;
		if (cyc == 127) begin
			nxt = $random(seed);
			frame_cnt <= frame_cnt + 1;
			adc_word <= nxt;
			sent[frame_cnt + 1] <= nxt;
		end
		i_aud_bclk <= cyc[1];
		i_aud_lrck <= (cyc >= 64);
		i_aud_adcdat <= (cyc < 64) ? adc_word[15 - cyc / 4] : 1'b0;
		// dac bits settle 3 clocks after each bclk fall
		if (cyc >= 9 && cyc <= 69 && cyc % 4 == 1) begin
			dec_sh <= {dec_sh[14:0], o_aud_dacdat};
		end
	end

	task automatic compare_value(input string name, input logic [31:0] got,
	                             input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// each decoded frame against its scheduled word
	always @(posedge i_clk) begin
		if (cyc == 70 && exp_frame.size() > 0 && exp_frame[0] == frame_cnt) begin
			compare_value("o_aud_dacdat word", {16'd0, dec_sh}, {16'd0, exp_word[0]});
			void'(exp_frame.pop_front());
			void'(exp_word.pop_front());
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the tests did not finish in the expected time");
		$display("Done: errors found");
		$finish;
	end

	// stepping rules of the playback path, one entry per frame strobe in play
	function automatic int build_ref(input bit fast, input bit slow, input bit interp,
	                                 input int speed, input int end_a);
		int spd;
		int addr;
		int k;
		int step;
		int p;
		int c;
		logic [15:0] prev;
		logic [15:0] cur;
		logic [31:0] val;
		spd = (speed == 0) ? 1 : (speed > 8) ? 8 : speed;
		addr = 0;
		k = 0;
		prev = '0;
		ref_q.delete();
		while (ref_q.size() < 1000) begin
			cur = rec_words[addr];
			if (fast) begin
				step = spd;
			end else if (slow) begin
				step = (k == spd - 1) ? 1 : 0;
			end else begin
				step = 1;
			end
			p = int'($signed(prev));
			c = int'($signed(cur));
			val = (!fast && slow && interp) ? p + (c - p) * k / spd : c;
			ref_q.push_back(val[15:0]);
			if (step != 0) begin
				prev = cur;
			end
			k = (!fast && slow && k != spd - 1) ? k + 1 : 0;
			if (addr + step >= end_a) begin
				break;
			end
			addr += step;
		end
		return ref_q.size();
	endfunction

	task automatic at_cyc(input int c);
		do @(posedge i_clk); while (cyc != c);
	endtask

	task automatic at_frame(input int f);
		do at_cyc(100); while (frame_cnt != f);
	endtask

	// one clock command pulse
	task automatic send_command(input bit start, input bit pause, input bit stop);
		i_start <= start;
		i_pause <= pause;
		i_stop <= stop;
		@(posedge i_clk);
		i_start <= 1'b0;
		i_pause <= 1'b0;
		i_stop <= 1'b0;
	endtask

	task automatic run_record(input string name, input int n);
		int f0;
		int e0;
		e0 = errors;
		i_play_sel <= 1'b0;
		// late in the frame, so no stray word gets captured before the strobe
		at_cyc(100);
		f0 = frame_cnt;
		send_command(1, 0, 0);
		at_frame(f0 + n);
		send_command(0, 0, 1);
		repeat (4) @(posedge i_clk);
		for (int i = 0; i < n; i++) begin
			compare_value($sformatf("mem[%0d]", i), {16'd0, mem[i]}, {16'd0, sent[f0 + 1 + i]});
			rec_words[i] = sent[f0 + 1 + i];
		end
		if (n > end_exp) begin
			end_exp = n;
		end
		compare_value("o_end_addr", {12'd0, o_end_addr}, end_exp);
		compare_value("o_state", o_state, aud_types_pkg::st_idle);
		tests++;
		$display("test %s: %0d errors", name, errors - e0);
	endtask

	task automatic run_play(input string name, input bit fast, input bit slow, input bit interp,
	                        input int speed, input int pa, input int pl);
		int n;
		int f0;
		int fr;
		int e0;
		e0 = errors;
		i_fast <= fast;
		i_slow <= slow;
		i_interp <= interp;
		i_speed <= speed[3:0];
		i_play_sel <= 1'b1;
		n = build_ref(fast, slow, interp, speed, end_exp);
		at_cyc(100);
		f0 = frame_cnt;
		// first frame plays the cleared sample, then one frame of latency
		fr = f0 + 1;
		exp_frame.push_back(fr++);
		exp_word.push_back('0);
		for (int i = 0; i < n - 1; i++) begin
			if (pl > 0 && i == pa) begin
				repeat (pl) begin
					exp_frame.push_back(fr++);
					exp_word.push_back('0);
				end
			end
			exp_frame.push_back(fr++);
			exp_word.push_back(ref_q[i]);
		end
		// last registered word is dropped, then silence in idle
		repeat (3) begin
			exp_frame.push_back(fr++);
			exp_word.push_back('0);
		end
		send_command(1, 0, 0);
		if (pl > 0) begin
			at_frame(f0 + 1 + pa);
			send_command(0, 1, 0);
			at_frame(f0 + 1 + pa + pl);
			// address stopped one past the last word taken before the pause
			compare_value("o_sram_addr in pause", {12'd0, o_sram_addr}, pa + 1);
			send_command(1, 0, 0);
		end
		while (exp_frame.size() != 0) begin
			@(posedge i_clk);
		end
		compare_value("o_state", o_state, aud_types_pkg::st_idle);
		tests++;
		$display("test %s: %0d errors", name, errors - e0);
	endtask

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = 16'(i * 16'h0101) ^ 16'h5a3c;
			rec_words[i] = '0;
		end
		i_rst_n = 1'b0;
		i_start = 1'b0;
		i_pause = 1'b0;
		i_stop = 1'b0;
		i_play_sel = 1'b0;
		i_speed = 4'd1;
		i_fast = 1'b0;
		i_slow = 1'b0;
		i_interp = 1'b0;
		i_aud_bclk = 1'b0;
		i_aud_lrck = 1'b0;
		i_aud_adcdat = 1'b0;
		repeat (2) @(posedge i_clk);
		i_rst_n <= 1'b1;
		run_record("record 20 words", 20);
		run_play("normal playback", 0, 0, 0, 1, 0, 0);
		run_play("fast speed 3", 1, 0, 0, 3, 0, 0);
		run_play("fast speed 0", 1, 0, 0, 0, 0, 0);
		run_play("slow hold speed 2", 0, 1, 0, 2, 0, 0);
		run_play("slow interp speed 4", 0, 1, 1, 4, 0, 0);
		run_play("pause and resume", 0, 0, 0, 1, 5, 3);
		run_record("short record keeps end", 5);
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: aud_assertions.sv
`timescale 1ns/1ps

module aud_sram_checks (
	input logic                       i_clk,
	input logic                       i_rst_n,
	input logic                       i_we_n,
	input aud_types_pkg::ctrl_state_e i_state
);

	// sram writes only while recording
	we_in_rec: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_we_n |-> i_state == aud_types_pkg::st_rec)
		else $error("sram write outside the record state");

	// write strobe is a single cycle
	we_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_we_n |=> i_we_n)
		else $error("sram write strobe longer than one cycle");

	// no encoding outside the enum
	state_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_state inside {aud_types_pkg::st_idle, aud_types_pkg::st_rec,
		                aud_types_pkg::st_rec_pause, aud_types_pkg::st_play,
		                aud_types_pkg::st_play_pause})
		else $error("controller state is not a legal member");

endmodule

bind aud_top aud_sram_checks u_sram_checks (
	.i_clk   (i_clk),
	.i_rst_n (i_rst_n),
	.i_we_n  (o_sram_we_n),
	.i_state (o_state)
);

// File: aud_top.sv
`timescale 1ns/1ps

module aud_top (
	input  logic                             i_clk,
	input  logic                             i_rst_n,
	input  logic                             i_start,
	input  logic                             i_pause,
	input  logic                             i_stop,
	input  logic                             i_play_sel,
	input  logic [aud_cfg_pkg::SPEED_W-1:0]  i_speed,
	input  logic                             i_fast,
	input  logic                             i_slow,
	input  logic                             i_interp,
	input  logic                             i_aud_bclk,
	input  logic                             i_aud_lrck,
	input  logic                             i_aud_adcdat,
	output logic                             o_aud_dacdat,
	output logic [aud_cfg_pkg::ADDR_W-1:0]   o_sram_addr,
	inout  wire  [aud_cfg_pkg::SAMPLE_W-1:0] io_sram_dq,
	output logic                             o_sram_we_n,
	output aud_types_pkg::ctrl_state_e       o_state,
	output logic [aud_cfg_pkg::ADDR_W-1:0]   o_end_addr
);

	// codec lines, {adcdat, lrck, bclk}, all through the same two flops
	logic [2:0] sync_1;
	logic [2:0] sync_2;
	logic       bclk_q;
	logic       lrck_q;
	logic       bclk_rise;
	logic       bclk_fall;
	logic       frame_strobe;
	logic       rec_en;
	logic       play_en;
	logic       rec_we;
	logic       play_last;
	logic       play_restart;
	logic       rec_bclk_rise;
	logic [aud_cfg_pkg::ADDR_W-1:0]   rec_addr;
	logic [aud_cfg_pkg::ADDR_W-1:0]   play_addr;
	logic [aud_cfg_pkg::SAMPLE_W-1:0] rec_data;
	logic [aud_cfg_pkg::SAMPLE_W-1:0] dac_sample;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sync_1 <= '0;
			sync_2 <= '0;
			bclk_q <= 1'b0;
			lrck_q <= 1'b0;
		end else begin
			sync_1 <= {i_aud_adcdat, i_aud_lrck, i_aud_bclk};
			sync_2 <= sync_1;
			bclk_q <= sync_2[0];
			lrck_q <= sync_2[1];
		end
	end

	assign bclk_rise = sync_2[0] & ~bclk_q;
	assign bclk_fall = ~sync_2[0] & bclk_q;
	// lrck falling edge opens the left word
	assign frame_strobe = ~sync_2[1] & lrck_q;

	// recorder only sees bit clocks while actually recording
	assign rec_bclk_rise = bclk_rise && (o_state == aud_types_pkg::st_rec);
	// same condition the controller uses to leave idle for play
	assign play_restart = (o_state == aud_types_pkg::st_idle) && i_start && i_play_sel;

	// write owns the bus for its single cycle, reads otherwise
	assign o_sram_we_n = ~rec_we;
	assign o_sram_addr = rec_we ? rec_addr : play_addr;
	assign io_sram_dq  = rec_we ? rec_data : 'z;

	aud_ctrl u_ctrl (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.i_pause     (i_pause),
		.i_stop      (i_stop),
		.i_play_sel  (i_play_sel),
		.i_rec_we    (rec_we),
		.i_rec_addr  (rec_addr),
		.i_play_last (play_last),
		.o_state     (o_state),
		.o_rec_en    (rec_en),
		.o_play_en   (play_en),
		.o_end_addr  (o_end_addr)
	);

	aud_recorder u_recorder (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_en           (rec_en),
		.i_frame_strobe (frame_strobe),
		.i_bclk_rise    (rec_bclk_rise),
		.i_adcdat       (sync_2[2]),
		.o_we           (rec_we),
		.o_addr         (rec_addr),
		.o_data         (rec_data)
	);

	aud_dsp u_dsp (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_en           (play_en),
		.i_restart      (play_restart),
		.i_frame_strobe (frame_strobe),
		.i_speed        (i_speed),
		.i_fast         (i_fast),
		.i_slow         (i_slow),
		.i_interp       (i_interp),
		.i_end_addr     (o_end_addr),
		.i_sram_data    (io_sram_dq),
		.o_addr         (play_addr),
		.o_sample       (dac_sample),
		.o_last         (play_last)
	);

	aud_player u_player (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_en           (play_en),
		.i_frame_strobe (frame_strobe),
		.i_bclk_fall    (bclk_fall),
		.i_sample       (dac_sample),
		.o_dacdat       (o_aud_dacdat)
	);

endmodule

// File: aud_player.sv
`timescale 1ns/1ps

module aud_player (
	input  logic                             i_clk,
	input  logic                             i_rst_n,
	input  logic                             i_en,
	input  logic                             i_frame_strobe,
	input  logic                             i_bclk_fall,
	input  logic [aud_cfg_pkg::SAMPLE_W-1:0] i_sample,
	output logic                             o_dacdat
);

	// bits sent since the frame strobe
	logic [aud_cfg_pkg::BIT_CNT_W-1:0] bit_cnt;
	logic [aud_cfg_pkg::SAMPLE_W-1:0]  shift_q;
	logic                              send_bit;

	assign send_bit = i_bclk_fall && (bit_cnt < aud_cfg_pkg::BIT_DONE);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bit_cnt  <= aud_cfg_pkg::BIT_DONE;
			o_dacdat <= 1'b0;
		end else if (i_frame_strobe) begin
			// lrck edge slot carries no data
			bit_cnt  <= '0;
			o_dacdat <= 1'b0;
		end else if (send_bit) begin
			bit_cnt  <= bit_cnt + 1'b1;
			o_dacdat <= shift_q[aud_cfg_pkg::SAMPLE_W-1];
		end else if (i_bclk_fall) begin
			// rest of the frame is silence
			o_dacdat <= 1'b0;
		end
	end

	// zero word whenever playback is off or paused
	always_ff @(posedge i_clk) begin
		if (i_frame_strobe) begin
			shift_q <= i_en ? i_sample : '0;
		end else if (send_bit) begin
			shift_q <= {shift_q[aud_cfg_pkg::SAMPLE_W-2:0], 1'b0};
		end
	end

endmodule

// File: aud_dsp.sv
`timescale 1ns/1ps

module aud_dsp (
	input  logic                             i_clk,
	input  logic                             i_rst_n,
	input  logic                             i_en,
	input  logic                             i_restart,
	input  logic                             i_frame_strobe,
	input  logic [aud_cfg_pkg::SPEED_W-1:0]  i_speed,
	input  logic                             i_fast,
	input  logic                             i_slow,
	input  logic                             i_interp,
	input  logic [aud_cfg_pkg::ADDR_W-1:0]   i_end_addr,
	input  logic [aud_cfg_pkg::SAMPLE_W-1:0] i_sram_data,
	output logic [aud_cfg_pkg::ADDR_W-1:0]   o_addr,
	output logic [aud_cfg_pkg::SAMPLE_W-1:0] o_sample,
	output logic                             o_last
);

	aud_types_pkg::play_mode_e mode;
	logic [aud_cfg_pkg::SPEED_W-1:0]      spd;
	// frame index inside a slow step
	logic [aud_cfg_pkg::SPEED_W-1:0]      k_cnt;
	logic                                 k_wrap;
	logic [aud_cfg_pkg::SPEED_W-1:0]      step;
	// one extra bit so the end compare cannot wrap
	logic [aud_cfg_pkg::ADDR_W:0]         next_addr;
	logic [aud_cfg_pkg::SAMPLE_W-1:0]     prev_sample;
	logic signed [aud_cfg_pkg::SAMPLE_W:0] diff;
	logic signed [aud_cfg_pkg::PROD_W-1:0] prod;
	logic signed [aud_cfg_pkg::PROD_W-1:0] quot;
	logic [aud_cfg_pkg::SAMPLE_W-1:0]     interp;
	logic                                 fire;

	// fast beats slow
	always_comb begin
		if (i_fast) begin
			mode = aud_types_pkg::mode_fast;
		end else if (i_slow) begin
			mode = i_interp ? aud_types_pkg::mode_slow_interp : aud_types_pkg::mode_slow_hold;
		end else begin
			mode = aud_types_pkg::mode_normal;
		end
	end

	// clamp speed into 1..8
	always_comb begin
		if (i_speed < aud_cfg_pkg::SPEED_MIN) begin
			spd = aud_cfg_pkg::SPEED_MIN;
		end else if (i_speed > aud_cfg_pkg::SPEED_MAX) begin
			spd = aud_cfg_pkg::SPEED_MAX;
		end else begin
			spd = i_speed;
		end
	end

	// >= so a speed change mid step still wraps
	assign k_wrap = (k_cnt >= spd - 1'b1);

	always_comb begin
		case (mode)
			aud_types_pkg::mode_fast:        step = spd;
			aud_types_pkg::mode_slow_hold,
			aud_types_pkg::mode_slow_interp: step = k_wrap ? 4'd1 : 4'd0;
			default:                         step = 4'd1;
		endcase
	end

	assign next_addr = {1'b0, o_addr} + step;
	assign fire = i_en && i_frame_strobe;

	// prev + (cur - prev) * k / speed, signed samples
	assign diff = $signed({i_sram_data[aud_cfg_pkg::SAMPLE_W-1], i_sram_data}) -
	              $signed({prev_sample[aud_cfg_pkg::SAMPLE_W-1], prev_sample});
	assign prod = diff * $signed({1'b0, k_cnt});

	// constant divisors only
	always_comb begin
		case (spd)
			4'd2:    quot = aud_cfg_pkg::PROD_W'(prod / 2);
			4'd3:    quot = aud_cfg_pkg::PROD_W'(prod / 3);
			4'd4:    quot = aud_cfg_pkg::PROD_W'(prod / 4);
			4'd5:    quot = aud_cfg_pkg::PROD_W'(prod / 5);
			4'd6:    quot = aud_cfg_pkg::PROD_W'(prod / 6);
			4'd7:    quot = aud_cfg_pkg::PROD_W'(prod / 7);
			4'd8:    quot = aud_cfg_pkg::PROD_W'(prod / 8);
			default: quot = prod;
		endcase
	end

	// result lies between prev and cur, low bits are enough
	assign interp = prev_sample + quot[aud_cfg_pkg::SAMPLE_W-1:0];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_addr      <= '0;
			k_cnt       <= '0;
			prev_sample <= '0;
			o_sample    <= '0;
			o_last      <= 1'b0;
		end else begin
			o_last <= 1'b0;
			if (i_restart) begin
				// fresh playback from word 0
				o_addr      <= '0;
				k_cnt       <= '0;
				prev_sample <= '0;
				o_sample    <= '0;
			end else if (fire) begin
				o_addr <= next_addr[aud_cfg_pkg::ADDR_W-1:0];
				o_last <= (next_addr >= {1'b0, i_end_addr});
				if (mode == aud_types_pkg::mode_slow_interp) begin
					o_sample <= interp;
				end else begin
					o_sample <= i_sram_data;
				end
				if (step != 4'd0) begin
					prev_sample <= i_sram_data;
				end
				// k only runs in the slow modes
				if (i_slow && !i_fast && !k_wrap) begin
					k_cnt <= k_cnt + 1'b1;
				end else begin
					k_cnt <= '0;
				end
			end
		end
	end

endmodule

// File: aud_recorder.sv
`timescale 1ns/1ps

module aud_recorder (
	input  logic                             i_clk,
	input  logic                             i_rst_n,
	input  logic                             i_en,
	input  logic                             i_frame_strobe,
	input  logic                             i_bclk_rise,
	input  logic                             i_adcdat,
	output logic                             o_we,
	output logic [aud_cfg_pkg::ADDR_W-1:0]   o_addr,
	output logic [aud_cfg_pkg::SAMPLE_W-1:0] o_data
);

	// bits captured since the frame strobe
	logic [aud_cfg_pkg::BIT_CNT_W-1:0] bit_cnt;
	logic [aud_cfg_pkg::SAMPLE_W-1:0]  shift_q;
	// a data bit is taken on this cycle
	logic                              take_bit;

	assign take_bit = i_bclk_rise && (bit_cnt < aud_cfg_pkg::BIT_DONE);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			// parked until the first frame
			bit_cnt <= aud_cfg_pkg::BIT_DONE;
			o_we    <= 1'b0;
			o_addr  <= '0;
		end else begin
			o_we <= 1'b0;
			if (i_frame_strobe) begin
				// left word starts here
				bit_cnt <= '0;
			end else if (take_bit) begin
				bit_cnt <= bit_cnt + 1'b1;
				// write lands the cycle after the 16th bit
				if (bit_cnt == aud_cfg_pkg::BIT_LAST) begin
					o_we <= i_en;
				end
			end
			// back in idle, next take starts at word 0
			if (!i_en) begin
				o_addr <= '0;
			end else if (o_we) begin
				o_addr <= o_addr + 1'b1;
			end
		end
	end

	// msb first, right channel bits are never shifted in
	always_ff @(posedge i_clk) begin
		if (take_bit) begin
			shift_q <= {shift_q[aud_cfg_pkg::SAMPLE_W-2:0], i_adcdat};
		end
	end

	assign o_data = shift_q;

endmodule

// File: aud_ctrl.sv
`timescale 1ns/1ps

module aud_ctrl (
	input  logic                             i_clk,
	input  logic                             i_rst_n,
	input  logic                             i_start,
	input  logic                             i_pause,
	input  logic                             i_stop,
	input  logic                             i_play_sel,
	input  logic                             i_rec_we,
	input  logic [aud_cfg_pkg::ADDR_W-1:0]   i_rec_addr,
	input  logic                             i_play_last,
	output aud_types_pkg::ctrl_state_e       o_state,
	output logic                             o_rec_en,
	output logic                             o_play_en,
	output logic [aud_cfg_pkg::ADDR_W-1:0]   o_end_addr
);

	aud_types_pkg::ctrl_state_e state_q;
	aud_types_pkg::ctrl_state_e state_d;
	// one past the word being written
	logic [aud_cfg_pkg::ADDR_W-1:0] rec_next;

	assign rec_next = i_rec_addr + 1'b1;

	// next state, pause checked before stop everywhere
	always_comb begin
		state_d = state_q;
		case (state_q)
			aud_types_pkg::st_idle: begin
				if (i_start) begin
					state_d = i_play_sel ? aud_types_pkg::st_play : aud_types_pkg::st_rec;
				end
			end
			aud_types_pkg::st_rec: begin
				if (i_pause) begin
					state_d = aud_types_pkg::st_rec_pause;
				end else if (i_stop) begin
					state_d = aud_types_pkg::st_idle;
				end
			end
			aud_types_pkg::st_rec_pause: begin
				if (i_start) begin
					state_d = aud_types_pkg::st_rec;
				end else if (i_stop) begin
					state_d = aud_types_pkg::st_idle;
				end
			end
			aud_types_pkg::st_play: begin
				if (i_pause) begin
					state_d = aud_types_pkg::st_play_pause;
				end else if (i_stop || i_play_last) begin
					// stepper ran into the end address
					state_d = aud_types_pkg::st_idle;
				end
			end
			aud_types_pkg::st_play_pause: begin
				if (i_start) begin
					state_d = aud_types_pkg::st_play;
				end else if (i_stop) begin
					state_d = aud_types_pkg::st_idle;
				end
			end
			default: state_d = aud_types_pkg::st_idle;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q    <= aud_types_pkg::st_idle;
			o_end_addr <= '0;
		end else begin
			state_q <= state_d;
			// end address only grows, a stop keeps it
			if (i_rec_we && (rec_next > o_end_addr)) begin
				o_end_addr <= rec_next;
			end
		end
	end

	assign o_state = state_q;
	// recorder keeps its address through a pause, so both rec states count
	assign o_rec_en = (state_q == aud_types_pkg::st_rec) ||
	                  (state_q == aud_types_pkg::st_rec_pause);
	assign o_play_en = (state_q == aud_types_pkg::st_play);

endmodule

// File: aud_types_pkg.sv
package aud_types_pkg;

	// controller states
	typedef enum logic [2:0] {
		st_idle,
		st_rec,
		st_rec_pause,
		st_play,
		st_play_pause
	} ctrl_state_e;

	// playback address stepping modes
	typedef enum logic [1:0] {
		// one word per frame
		mode_normal,
		// skip ahead by the speed factor
		mode_fast,
		// repeat each word speed times
		mode_slow_hold,
		// linear ramp between neighbours
		mode_slow_interp
	} play_mode_e;

endpackage

// File: aud_cfg_pkg.sv
package aud_cfg_pkg;

	// bits per audio sample, also the sram word width
	localparam int SAMPLE_W = 16;

	// sram address width, one word per location
	localparam int ADDR_W = 20;

	// speed factor switch width
	localparam int SPEED_W = 4;

	// legal speed range, 0 reads as 1 and anything above 8 is clamped
	localparam logic [SPEED_W-1:0] SPEED_MIN = 4'd1;
	localparam logic [SPEED_W-1:0] SPEED_MAX = 4'd8;

	// bit counter of the i2s shifters
	localparam int BIT_CNT_W = 5;
	// index of the last data bit in a word
	localparam logic [BIT_CNT_W-1:0] BIT_LAST = 5'd15;
	// counter value once a whole word has been moved
	localparam logic [BIT_CNT_W-1:0] BIT_DONE = 5'd16;

	// interpolation product, signed difference times frame index
	localparam int PROD_W = SAMPLE_W + SPEED_W + 2;

endpackage
